/* src.f */
+incdir+common
common/fetch_pkg.sv
common/imem_load_if.sv
fetch/pc_unit.sv
fetch/instr_rom.sv
logic/imem_loader.sv
fetch/fetch_top.sv
test/fetch_props.sv
test/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vfetch_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Everything OK" "$LOG"; then
    exit 0
fi
exit 1

/* test/fetch_tb.sv */
`default_nettype none

`include "fetch_config.svh"

module fetch_tb
    import fetch_pkg::*;
;

    localparam int TABLE_LEN = 14;
    localparam int APB_OPS   = 70;                      // register accesses, 3 cycles each
    localparam int SEQ_LEN   = 24;                      // free running fetch cycles
    localparam int LIMIT     = TABLE_LEN + 3 * APB_OPS + SEQ_LEN + 200;

    typedef struct packed {
        logic  branch_taken;
        word_t branch_offset;
        logic  jump_taken;
        word_t jump_target;
        logic  hold;
        logic  no_op_req;
    } row_t;

    logic      clk, rst_n, psel, penable, pwrite, pready, pslverr;
    apb_addr_t paddr;
    word_t     pwdata, prdata, branch_offset, jump_target, pc, instruction;
    logic      branch_taken, jump_taken, hold, no_op_req, if_no_op, load_busy;

    row_t       stim [TABLE_LEN];
    word_t      shadow [`IMEM_DEPTH];                   // loaded program copy
    logic       valid [`IMEM_DEPTH];                    // shadow word written
    word_t      m_pc, m_instr;
    logic       m_known, m_no_op, m_mode, m_restart;
    imem_addr_t m_addr;
    int         checks = 0, errors = 0, test_errs = 0, tests = 0, cycles = 0;

    fetch_top u_fetch_top (.*);

    bind fetch_top fetch_props u_fetch_props (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    // reference model, updated from the inputs seen at each rising edge
    always @(posedge clk or negedge rst_n) begin
        int    srcs;
        word_t nxt;
        if (!rst_n) begin
            m_pc      = 32'h0;
            m_instr   = 32'h0;
            m_known   = 1'b1;                           // instruction resets to zero
            m_no_op   = 1'b0;
            m_mode    = 1'b0;
            m_restart = 1'b0;
            m_addr    = '0;
            foreach (valid[i]) valid[i] = 1'b0;
        end else begin
            srcs = int'(branch_taken) + int'(jump_taken) + int'(m_restart);
            if (srcs == 1 && branch_taken) begin
                nxt = m_pc + 32'd4 + branch_offset * 32'd4;
            end else if (srcs == 1 && jump_taken) begin
                nxt = jump_target;
            end else if (srcs == 1) begin
                nxt = 32'h0;                            // restart after load
            end else begin
                nxt = m_pc + 32'd4;                     // none or overlap
            end
            if (!m_mode && !m_no_op) begin              // rom reads old pc
                m_known = valid[m_pc[`IMEM_AW+1:2]];
                m_instr = shadow[m_pc[`IMEM_AW+1:2]];
            end
            if (!hold && !m_mode) begin
                m_pc = nxt;
            end
            m_no_op   = no_op_req;
            m_restart = 1'b0;
            if (psel && penable && pwrite) begin
                if (paddr == `REG_CTRL) begin
                    m_restart = m_mode && !pwdata[0];
                    m_mode    = pwdata[0];
                end else if (paddr == `REG_ADDR) begin
                    m_addr = pwdata[`IMEM_AW-1:0];
                end else if (paddr == `REG_DATA && m_mode) begin
                    shadow[m_addr] = pwdata;
                    valid[m_addr]  = 1'b1;
                    m_addr         = m_addr + imem_addr_t'(1);
                end
            end
        end
    end

    task automatic check_word(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errs++;
            $display("MISMATCH %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errs++;
            $display("MISMATCH %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic apb_access(input logic wr, input apb_addr_t addr, input word_t data,
                              output word_t rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;                                 // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #2;                                             // outputs settled mid low phase
        rdata = prdata;
        err   = pslverr;
        check_bit("pready in access phase", pready, 1'b1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input word_t data, input logic exp_err);
        word_t rd;
        logic  err;
        apb_access(1'b1, addr, data, rd, err);
        check_bit($sformatf("pslverr of write to %h", addr), err, exp_err);
    endtask

    task automatic check_apb(input string what, input apb_addr_t addr, input word_t exp,
                             input logic exp_err);
        word_t rd;
        logic  err;
        apb_access(1'b0, addr, 32'h0, rd, err);
        check_word(what, rd, exp);
        check_bit({what, " pslverr"}, err, exp_err);
    endtask

    task automatic drive_row(input row_t r);
        branch_taken  = r.branch_taken;
        branch_offset = r.branch_offset;
        jump_taken    = r.jump_taken;
        jump_target   = r.jump_target;
        hold          = r.hold;
        no_op_req     = r.no_op_req;
    endtask

    task automatic compare_fetch();
        check_word("pc", pc, m_pc);
        if (m_known) begin                              // unwritten rom words are skipped
            check_word("instruction", instruction, m_instr);
        end
        check_bit("if_no_op", if_no_op, m_no_op);
        check_bit("load_busy", load_busy, m_mode);
    endtask

    task automatic fetch_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            compare_fetch();
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s: %s, %0d errors", name, test_errs == 0 ? "passed" : "FAILED",
                 test_errs);
        test_errs = 0;
    endtask

    initial begin
        word_t frozen;
        void'($urandom(19));
        // branch, offset, jump, target, hold, no_op
        stim[0]  = '{1'b0, 32'h0,         1'b1, 32'h10, 1'b0, 1'b0};  // back into program
        stim[1]  = '{1'b0, 32'h0,         1'b0, 32'h0,  1'b0, 1'b0};
        stim[2]  = '{1'b1, 32'd3,         1'b0, 32'h0,  1'b0, 1'b0};  // forward branch
        stim[3]  = '{1'b1, 32'hFFFF_FFFB, 1'b0, 32'h0,  1'b0, 1'b0};  // back by 5 words
        stim[4]  = '{1'b1, 32'd6,         1'b1, 32'h70, 1'b0, 1'b0};  // overlap gives pc+4
        stim[5]  = '{1'b0, 32'h0,         1'b0, 32'h0,  1'b1, 1'b0};
        stim[6]  = '{1'b1, 32'd2,         1'b0, 32'h0,  1'b1, 1'b0};  // hold beats branch
        stim[7]  = '{1'b0, 32'h0,         1'b0, 32'h0,  1'b0, 1'b1};
        stim[8]  = '{1'b0, 32'h0,         1'b0, 32'h0,  1'b0, 1'b0};  // word frozen here
        stim[9]  = '{1'b0, 32'h0,         1'b1, 32'h40, 1'b0, 1'b1};
        stim[10] = '{1'b1, 32'hFFFF_FFFF, 1'b0, 32'h0,  1'b0, 1'b1};
        stim[11] = '{1'b0, 32'h0,         1'b1, 32'h7C, 1'b0, 1'b0};
        stim[12] = '{1'b1, 32'd1,         1'b1, 32'h4,  1'b0, 1'b0};
        stim[13] = '{1'b0, 32'h0,         1'b1, 32'h8,  1'b0, 1'b0};
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        drive_row('0);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_word("pc after reset", pc, 32'h0);
        check_word("instruction after reset", instruction, 32'h0);
        check_bit("if_no_op after reset", if_no_op, 1'b0);
        check_bit("load_busy after reset", load_busy, 1'b0);
        check_apb("ctrl after reset", `REG_CTRL, 32'h0, 1'b0);
        end_test("reset");

        apb_write(`REG_CTRL, 32'h1, 1'b0);
        apb_write(`REG_ADDR, 32'h0, 1'b0);
        repeat (32) apb_write(`REG_DATA, $urandom, 1'b0);
        check_bit("load_busy in load mode", load_busy, 1'b1);
        check_apb("status", `REG_STATUS, 32'd32, 1'b0);
        check_apb("addr", `REG_ADDR, 32'd32, 1'b0);
        end_test("load");

        apb_write(`REG_CTRL, 32'h0, 1'b0);
        @(negedge clk);
        check_word("pc after restart", pc, 32'h0);
        compare_fetch();
        fetch_cycles(SEQ_LEN / 2);
        end_test("restart");

        apb_write(`REG_DATA, 32'hDEAD_BEEF, 1'b1);      // not in load mode
        apb_write(4'h2, 32'h1, 1'b1);                   // 4 bit offset space, 0x2 unmapped
        check_apb("unmapped read", 4'h2, 32'h0, 1'b1);
        check_apb("addr kept", `REG_ADDR, 32'd32, 1'b0);
        check_apb("status kept", `REG_STATUS, 32'd32, 1'b0);
        check_apb("ctrl kept", `REG_CTRL, 32'h0, 1'b0);
        end_test("apb_errors");

        for (int i = 0; i < TABLE_LEN; i++) begin
            @(negedge clk);
            compare_fetch();                            // result of the previous row
            drive_row(stim[i]);
        end
        @(negedge clk);
        compare_fetch();
        drive_row('0);
        end_test("table");

        apb_write(`REG_CTRL, 32'h1, 1'b0);
        frozen = m_pc;                                  // model pc at load entry
        apb_write(`REG_ADDR, 32'h0, 1'b0);
        repeat (16) apb_write(`REG_DATA, $urandom, 1'b0);
        check_word("pc while loading", pc, frozen);
        compare_fetch();
        apb_write(`REG_CTRL, 32'h0, 1'b0);
        @(negedge clk);
        check_word("pc after reload", pc, 32'h0);
        fetch_cycles(SEQ_LEN / 2);
        end_test("reload");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/fetch_props.sv */
`default_nettype none

module fetch_props
    import fetch_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  psel,
    input logic  penable,
    input logic  pready,
    input logic  pslverr,
    input logic  load_busy,
    input logic  no_op_req,
    input logic  if_no_op,
    input word_t pc
);

    a_pready: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else $error("pready dropped low");      // slave has no wait states

    a_err_access: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> (psel && penable))
        else $error("pslverr outside access phase");

    a_load_freeze: assert property (@(posedge clk) disable iff (!rst_n)
        load_busy |=> $stable(pc))
        else $error("pc moved while loading");  // loader acts as a hold

    a_no_op_reg: assert property (@(posedge clk) disable iff (!rst_n)
        if_no_op == $past(no_op_req))
        else $error("if_no_op is not last cycle no_op_req");

endmodule

`default_nettype wire

/* fetch/fetch_top.sv */
`default_nettype none

module fetch_top
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // apb slave, program loading
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  word_t     pwdata,
    output word_t     prdata,
    output logic      pready,
    output logic      pslverr,
    // fetch control from later stages
    input  logic      branch_taken,
    input  word_t     branch_offset,
    input  logic      jump_taken,
    input  word_t     jump_target,
    input  logic      hold,
    input  logic      no_op_req,
    // fetch results
    output word_t     pc,
    output word_t     instruction,
    output logic      if_no_op,
    output logic      load_busy
);

    logic pc_restart;                   // loader to pc, end of load

    imem_load_if load_bus ();

    imem_loader u_imem_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .load       (load_bus.loader),
        .pc_restart (pc_restart),
        .load_busy  (load_busy)
    );

    pc_unit u_pc_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .branch_taken  (branch_taken),
        .branch_offset (branch_offset),
        .jump_taken    (jump_taken),
        .jump_target   (jump_target),
        .pc_restart    (pc_restart),
        .hold          (hold),
        .load_busy     (load_busy),     // extra hold while loading
        .no_op_req     (no_op_req),
        .pc            (pc),
        .if_no_op      (if_no_op)
    );

    instr_rom u_instr_rom (
        .clk         (clk),
        .rst_n       (rst_n),
        .load        (load_bus.rom),
        .pc          (pc),
        .if_no_op    (if_no_op),
        .instruction (instruction)
    );

endmodule

`default_nettype wire

/* logic/imem_loader.sv */
`default_nettype none

`include "fetch_config.svh"

module imem_loader
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apb_addr_t   paddr,
    input  word_t       pwdata,
    output word_t       prdata,
    output logic        pready,
    output logic        pslverr,
    imem_load_if.loader load,           // rom write path
    output logic        pc_restart,     // pulse the cycle after load ends
    output logic        load_busy       // fetch paused
);

    load_state_e state;
    imem_addr_t  load_addr;             // next word index to store
    word_t       word_cnt;              // words stored since load entry

    logic access;                       // apb access phase
    logic addr_hit;                     // offset maps to a register
    logic ctrl_wr;
    logic addr_wr;
    logic data_wr;
    logic store;                        // data write accepted

    assign access  = psel && penable;
    assign ctrl_wr = access && pwrite && (paddr == `REG_CTRL);
    assign addr_wr = access && pwrite && (paddr == `REG_ADDR);
    assign data_wr = access && pwrite && (paddr == `REG_DATA);
    assign store   = data_wr && (state == loading);

    assign load_busy = (state == loading);
    assign pready    = 1'b1;            // no wait states

    // decode of the four mapped offsets
    always_comb begin
        case (paddr)
            `REG_CTRL, `REG_ADDR, `REG_DATA, `REG_STATUS: addr_hit = 1'b1;
            default:                                      addr_hit = 1'b0;
        endcase
    end

    // error only in access phase, bad offset or data write outside load
    assign pslverr = access && (!addr_hit || (data_wr && !load_busy));

    // read mux, data reads back as zero
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                `REG_CTRL:   prdata = {31'b0, load_busy};
                `REG_ADDR:   prdata = word_t'(load_addr);
                `REG_STATUS: prdata = word_cnt;
                default:     prdata = '0;
            endcase
        end
    end

    // rom gets the data word at the same edge as the apb write
    assign load.active = load_busy;
    assign load.wen    = store;
    assign load.addr   = load_addr;
    assign load.data   = pwdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= idle;
            load_addr  <= '0;
            word_cnt   <= '0;
            pc_restart <= 1'b0;
        end else begin
            pc_restart <= 1'b0;         // single cycle pulse
            case (state)
                idle: begin
                    if (ctrl_wr && pwdata[0]) begin
                        state    <= loading;
                        word_cnt <= '0; // fresh count per load
                    end
                end
                loading: begin
                    if (ctrl_wr && !pwdata[0]) begin
                        state      <= idle;
                        pc_restart <= 1'b1;  // pc back to start next edge
                    end
                end
                default: state <= idle;
            endcase
            if (addr_wr) begin
                load_addr <= pwdata[`IMEM_AW-1:0];
            end else if (store) begin
                load_addr <= load_addr + 1'b1;  // auto increment
                word_cnt  <= word_cnt + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* fetch/instr_rom.sv */
`default_nettype none

`include "fetch_config.svh"

module instr_rom
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    imem_load_if.rom        load,       // loader write port
    input  word_t           pc,         // byte address of the fetch
    input  logic            if_no_op,   // keep last word
    output word_t           instruction
);

    word_t      mem [`IMEM_DEPTH];      // program storage, no reset
    imem_addr_t rd_idx;
    logic       rd_en;

    assign rd_idx = pc[`IMEM_AW+1:2];   // byte pc to word index
    assign rd_en  = !load.active && !if_no_op;

    // single port, loader owns it while active
    always_ff @(posedge clk) begin
        if (load.active && load.wen) begin
            mem[load.addr] <= load.data;
        end
    end

    // registered read, one cycle behind pc
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instruction <= '0;
        end else if (rd_en) begin
            instruction <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

/* fetch/pc_unit.sv */
`default_nettype none

`include "fetch_config.svh"

module pc_unit
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  branch_taken,         // relative branch request
    input  word_t branch_offset,        // word offset, scaled by 4 here
    input  logic  jump_taken,           // absolute jump request
    input  word_t jump_target,          // byte address
    input  logic  pc_restart,           // one cycle pulse after loading ends
    input  logic  hold,                 // pipeline hold, freeze pc
    input  logic  load_busy,            // loader active, freeze pc too
    input  logic  no_op_req,            // freeze fetched word next cycle
    output word_t pc,
    output logic  if_no_op              // registered no_op_req, gates rom
);

    word_t pc_inc;                      // sequential successor
    word_t pc_next;
    logic  pc_freeze;

    assign pc_inc    = pc + 32'd4;
    assign pc_freeze = hold || load_busy;

    // one-hot select, any overlap falls back to pc+4
    always_comb begin
        case ({branch_taken, jump_taken, pc_restart})
            3'b100:  pc_next = pc_inc + (branch_offset << 2);  // offset in words
            3'b010:  pc_next = jump_target;
            3'b001:  pc_next = `RESET_PC;                      // restart after load
            default: pc_next = pc_inc;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= `RESET_PC;
            if_no_op <= 1'b0;
        end else begin
            if (!pc_freeze) begin
                pc <= pc_next;
            end
            if_no_op <= no_op_req;      // follows request every edge, hold or not
        end
    end

endmodule

`default_nettype wire

/* common/imem_load_if.sv */
`default_nettype none

// rom write path from the apb loader into the instruction rom
interface imem_load_if
    import fetch_pkg::*;
;

    logic       active;                 // load mode on, rom belongs to loader
    logic       wen;                    // store data at addr this edge
    imem_addr_t addr;                   // word index
    word_t      data;                   // word to store

    modport loader (
        output active,
        output wen,
        output addr,
        output data
    );

    modport rom (
        input active,
        input wen,
        input addr,
        input data
    );

endinterface

`default_nettype wire

/* common/fetch_pkg.sv */
`default_nettype none

`include "fetch_config.svh"

package fetch_pkg;

    // instruction, pc and apb data word
    typedef logic [31:0] word_t;

    // rom word index, byte pc >> 2
    typedef logic [`IMEM_AW-1:0] imem_addr_t;

    // apb register offset
    typedef logic [3:0] apb_addr_t;

    // loader fsm
    typedef enum logic {
        idle,                           // fetch running
        loading                         // rom owned by the loader
    } load_state_e;

endpackage

`default_nettype wire

/* common/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// instruction rom geometry
`define IMEM_AW     8                   // word index width
`define IMEM_DEPTH  (1 << `IMEM_AW)     // words in the rom

// pc value after reset and after a load restart
`define RESET_PC    32'h0000_0000

// apb register offsets of the loader
`define REG_CTRL    4'h0                // bit 0 load_mode
`define REG_ADDR    4'h4                // next load word index
`define REG_DATA    4'h8                // write only, stores and increments
`define REG_STATUS  4'hC                // words stored in this load

`endif
